// ==== hdl/cheat_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cheat engine shared package
// Widths, bus structs, port map and
// constants for the port-side blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package cheat_pkg;

    localparam int unsigned SDRAM_AW = 22;

    typedef logic [7:0]          port_id_t;
    typedef logic [7:0]          port_data_t;
    typedef logic [SDRAM_AW-1:0] sdram_addr_t;
    typedef logic [15:0]         sdram_data_t;
    typedef logic [1:0]          sdram_mask_t;
    typedef logic [9:0]          vram_addr_t;
    typedef logic [31:0]         time_t;

    // Processor port bus, as seen from the peripherals
    typedef struct packed {
        port_id_t   port_id;
        port_data_t out_port;
        logic       write_strobe;
        logic       k_write_strobe;
        logic       read_strobe;
    } port_bus_t;

    typedef struct packed {
        sdram_addr_t addr;
        logic        rd;
        logic        wr;
        sdram_data_t din;
        sdram_mask_t din_m;     // Byte write mask
    } sdram_req_t;

    typedef struct packed {
        logic        ack;       // Request taken
        logic        dst;       // Data word on the bus
        logic        rdy;       // End of transaction
        sdram_data_t data;
    } sdram_rsp_t;

    typedef struct packed {
        vram_addr_t addr;
        port_data_t data;
        logic       we;
        logic [2:0] ctrl;
    } vram_wr_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_GAME,
        ARB_CHEAT
    } arb_state_t;

    localparam int unsigned FRAMES_PER_SEC  = 60;
    localparam int unsigned WATCHDOG_FRAMES = 8;
    localparam time_t       UNLOCK_KEY      = 32'h5a3c_96e1;
    localparam time_t       BUILD_TIME      = 32'h65f0_1a20;

    // Port map
    localparam port_id_t PORT_SCRATCH_LAST = 8'h05;
    localparam port_id_t PORT_SDRAM_LSB    = 8'h06;
    localparam port_id_t PORT_SDRAM_MSB    = 8'h07;
    localparam port_id_t PORT_VRAM_BASE    = 8'h08;
    localparam port_id_t PORT_LED          = 8'h06;  // Shares the SDRAM LSB number
    localparam port_id_t PORT_ST_ADDR      = 8'h0c;
    localparam port_id_t PORT_FLAGS        = 8'h10;
    localparam port_id_t PORT_STATUS       = 8'h14;
    localparam port_id_t PORT_JOY1         = 8'h18;
    localparam port_id_t PORT_JOY2         = 8'h48;
    localparam port_id_t PORT_TIME         = 8'h20;
    localparam port_id_t PORT_KEY          = 8'h30;
    localparam port_id_t PORT_CTRL         = 8'h80;

endpackage

// ==== hdl/cheat_timekeeper.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cheat timekeeper
// Frame and second counts from the
// vertical blank, uptime and the
// frame watchdog of the processor
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module cheat_timekeeper import cheat_pkg::*; (
    input  logic       clk,
    input  logic       prst,
    input  logic       lvbl,
    input  time_t      timestamp,
    input  port_bus_t  bus,
    output logic [5:0] frame_cnt,
    output time_t      uptime,
    output logic       wd_bite
);

    logic        lvbl_last;
    logic        vb_fall;
    logic [23:0] sec_cnt;       // About 194 days before wrapping
    logic [3:0]  watchdog;
    logic        kick;

    assign vb_fall = lvbl_last & ~lvbl;
    // Any write into 0x40..0x7f counts as a kick
    assign kick    = (bus.write_strobe | bus.k_write_strobe) && bus.port_id[7:6] == 2'b01;
    assign uptime  = timestamp + {8'd0, sec_cnt};
    assign wd_bite = watchdog == 4'(WATCHDOG_FRAMES);

    always_ff @(posedge clk) begin
        if (prst) begin
            lvbl_last <= 1'b0;
            frame_cnt <= '0;
            sec_cnt   <= '0;
        end else begin
            lvbl_last <= lvbl;
            if (vb_fall) begin
                if (frame_cnt == 6'(FRAMES_PER_SEC - 1)) begin
                    frame_cnt <= '0;
                    sec_cnt   <= sec_cnt + 24'd1;
                end else begin
                    frame_cnt <= frame_cnt + 6'd1;
                end
            end
        end
    end

    // Watchdog clears itself when it bites
    always_ff @(posedge clk) begin
        if (prst || kick || wd_bite) begin
            watchdog <= '0;
        end else if (vb_fall) begin
            watchdog <= watchdog + 4'd1;
        end
    end

    assert property (@(posedge clk) disable iff (prst)
        frame_cnt < 6'(FRAMES_PER_SEC))
        else $error("frame_cnt left the 0..59 range");

endmodule

// ==== hdl/cheat_lock.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cheat unlock key
// Four key bytes from the port bus
// or the loader, compared against
// the unlock constant
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module cheat_lock import cheat_pkg::*; (
    input  logic        clk,
    input  logic        prst,
    input  port_bus_t   bus,
    input  logic        prog_lock,
    input  logic        prog_wr,
    input  port_id_t    prog_addr,
    input  port_data_t  prog_data,
    output logic [31:0] key_bytes,
    output logic        locked
);

    port_data_t key_q [4];
    logic       key_port;
    logic       key_load;

    // Ports 0x30..0x33
    assign key_port  = bus.write_strobe && bus.port_id[7:2] == PORT_KEY[7:2];
    assign key_load  = prog_lock & prog_wr;
    assign key_bytes = {key_q[3], key_q[2], key_q[1], key_q[0]};

    always_ff @(posedge clk) begin
        if (prst) begin
            key_q  <= '{default: '0};
            locked <= 1'b1;
        end else begin
            if (key_port) begin
                key_q[bus.port_id[1:0]] <= bus.out_port;
            end
            if (key_load) begin
                key_q[prog_addr[1:0]] <= prog_data;   // Loader wins on a clash
            end
            // Follows the key one cycle later
            locked <= key_bytes != UNLOCK_KEY;
        end
    end

endmodule

// ==== hdl/cheat_sdram_arbiter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cheat SDRAM arbiter
// Shares one SDRAM bank between the
// game and the cheat engine, with
// the game served first
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module cheat_sdram_arbiter import cheat_pkg::*; (
    input  logic        clk,
    input  logic        prst,
    input  port_bus_t   bus,
    input  logic        locked,
    input  logic [47:0] scratch,
    input  sdram_req_t  game_req,
    output sdram_rsp_t  game_rsp,
    output sdram_req_t  bank_req,
    input  sdram_rsp_t  bank_rsp,
    output sdram_data_t sdram_word,
    output logic        owner,
    output logic        cheat_busy
);

    arb_state_t arb_state;
    logic       cheat_req;
    logic       cheat_wr;
    logic       cheat_go;
    logic       cheat_grant;
    sdram_req_t cheat_side;

    // Port bit 7 starts a transfer, bit 6 picks write
    assign cheat_go    = bus.write_strobe && bus.port_id[7] && !locked;
    assign cheat_grant = arb_state == ARB_CHEAT;
    assign cheat_busy  = cheat_req | cheat_grant;

    // Scratch ports 0..2 address, 3..4 data, 5 mask
    always_comb begin
        cheat_side.addr  = scratch[SDRAM_AW-1:0];
        cheat_side.din   = scratch[39:24];
        cheat_side.din_m = scratch[41:40];
        cheat_side.rd    = cheat_req & ~cheat_wr & cheat_grant;
        cheat_side.wr    = cheat_req &  cheat_wr & cheat_grant;
    end

    always_ff @(posedge clk) begin
        if (prst) begin
            cheat_req <= 1'b0;
            cheat_wr  <= 1'b0;
        end else begin
            if (cheat_go) begin
                cheat_req <= 1'b1;
                cheat_wr  <= bus.port_id[6];
            end
            if (bank_rsp.ack && owner) begin
                cheat_req <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bank_rsp.dst && owner) begin
            sdram_word <= bank_rsp.data;       // Read back through ports 6 and 7
        end
    end

    always_ff @(posedge clk) begin
        if (prst) begin
            arb_state <= ARB_IDLE;
            owner     <= 1'b0;
        end else begin
            case (arb_state)
                ARB_IDLE: begin
                    owner <= 1'b0;             // Bank back with the game when idle
                    if (game_req.rd || game_req.wr) begin
                        arb_state <= ARB_GAME;
                    end else if (cheat_req) begin
                        arb_state <= ARB_CHEAT;
                        owner     <= 1'b1;
                    end
                end
                ARB_GAME, ARB_CHEAT: begin
                    if (bank_rsp.rdy) begin
                        arb_state <= ARB_IDLE;
                    end
                end
                default: arb_state <= ARB_IDLE;
            endcase
        end
    end

    // Bank routing follows the owner and hides game pulses from a cheat access
    assign bank_req      = owner ? cheat_side : game_req;
    assign game_rsp.ack  = ~owner & bank_rsp.ack;
    assign game_rsp.dst  = ~owner & bank_rsp.dst;
    assign game_rsp.rdy  = ~owner & bank_rsp.rdy;
    assign game_rsp.data = bank_rsp.data;

    assert property (@(posedge clk) disable iff (prst)
        !(bank_req.rd && bank_req.wr))
        else $error("bank request with rd and wr together");

endmodule

// ==== hdl/cheat_port_bus.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cheat port bus
// Processor write registers, VRAM
// write path and the registered
// read multiplexer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module cheat_port_bus import cheat_pkg::*; (
    input  logic        clk,
    input  logic        prst,
    input  port_bus_t   bus,
    input  time_t       flags,
    input  time_t       status,
    input  port_data_t  joy1,
    input  port_data_t  joy2,
    input  port_data_t  st_dout,
    input  port_data_t  debug_bus,
    input  port_data_t  vram_din,
    input  logic [5:0]  frame_cnt,
    input  time_t       uptime,
    input  time_t       timestamp,
    input  logic [31:0] key_bytes,
    input  logic        locked,
    input  sdram_data_t sdram_word,
    input  logic        owner,
    input  logic        cheat_busy,
    input  logic        lvbl,
    output logic [47:0] scratch,
    output port_data_t  st_addr,
    output logic        led,
    output vram_wr_t    vram_wr,
    output port_data_t  read_data
);

    port_data_t scratch_q [6];
    vram_addr_t vram_addr;
    port_data_t vram_data;
    logic       vram_we;
    logic [2:0] vram_ctrl;
    logic       wr;
    logic       vram_sel;
    port_data_t time_byte;

    function automatic port_data_t byte_of(input time_t word, input logic [1:0] idx);
        return word[8*idx +: 8];
    endfunction

    assign wr       = bus.write_strobe | bus.k_write_strobe;
    assign vram_sel = wr && bus.port_id[7:3] == PORT_VRAM_BASE[7:3];   // 0x08..0x0f
    assign scratch  = {scratch_q[5], scratch_q[4], scratch_q[3],
                       scratch_q[2], scratch_q[1], scratch_q[0]};
    assign vram_wr  = '{addr: vram_addr, data: vram_data, we: vram_we, ctrl: vram_ctrl};

    always_ff @(posedge clk) begin
        if (wr && bus.port_id <= PORT_SCRATCH_LAST) begin
            scratch_q[bus.port_id[2:0]] <= bus.out_port;
        end
        if (vram_sel) begin
            case (bus.port_id[2:0])
                3'd0:    vram_addr[4:0] <= bus.out_port[4:0];
                3'd1:    vram_addr[9:5] <= bus.out_port[4:0];
                3'd2:    vram_data      <= {1'b1, bus.out_port[6:0]};  // Bit 7 marks a write
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (prst) begin
            led       <= 1'b0;
            st_addr   <= '0;
            vram_we   <= 1'b0;
            vram_ctrl <= '0;
        end else begin
            vram_we <= vram_sel && bus.port_id[2:0] == 3'd2;  // Single cycle pulse
            if (vram_sel && bus.port_id[2:0] == 3'd3) begin
                vram_ctrl <= bus.out_port[2:0];
            end
            if (wr && bus.port_id == PORT_LED) begin
                led <= bus.out_port[0];
            end
            if (wr && bus.port_id == PORT_ST_ADDR) begin
                st_addr <= bus.out_port;
            end
        end
    end

    // Time page 0x20..0x2f
    always_comb begin
        case (bus.port_id[3:2])
            2'd0:    time_byte = byte_of(timestamp, bus.port_id[1:0]);
            2'd1:    time_byte = byte_of(BUILD_TIME, bus.port_id[1:0]);
            2'd2:    time_byte = byte_of(uptime, bus.port_id[1:0]);
            default: time_byte = bus.port_id[1:0] == 2'd0 ? {2'b00, frame_cnt} : '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (prst) begin
            read_data <= '0;
        end else if (bus.read_strobe) begin
            case (bus.port_id) inside
                [8'h00:PORT_SCRATCH_LAST]:        read_data <= scratch_q[bus.port_id[2:0]];
                PORT_SDRAM_LSB:                   read_data <= sdram_word[7:0];
                PORT_SDRAM_MSB:                   read_data <= sdram_word[15:8];
                PORT_VRAM_BASE + 8'd2:            read_data <= vram_din;
                PORT_ST_ADDR + 8'd1:              read_data <= st_dout;
                PORT_ST_ADDR + 8'd3:              read_data <= debug_bus;
                [PORT_FLAGS:PORT_FLAGS + 8'd3]:   read_data <= byte_of(flags, bus.port_id[1:0]);
                [PORT_STATUS:PORT_STATUS + 8'd3]: read_data <= byte_of(status, bus.port_id[1:0]);
                PORT_JOY1:                        read_data <= joy1;
                PORT_JOY2:                        read_data <= joy2;
                [PORT_TIME:PORT_TIME + 8'h0f]:    read_data <= time_byte;
                [PORT_KEY:PORT_KEY + 8'd3]:       read_data <= byte_of(key_bytes, bus.port_id[1:0]);
                // Expired bit always clear
                PORT_CTRL: read_data <= {owner, cheat_busy, lvbl, 3'b000, 1'b0, locked};
                default:   read_data <= '0;
            endcase
        end
    end

endmodule

// ==== hdl/cheat_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cheat engine top level
// Peripherals around the cheat
// processor and its reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module cheat_top import cheat_pkg::*; (
    input  logic       clk,
    input  logic       prst,
    input  logic       lvbl,
    input  time_t      timestamp,
    input  port_bus_t  bus,
    input  time_t      flags,
    input  time_t      status,
    input  port_data_t joy1,
    input  port_data_t joy2,
    input  port_data_t st_dout,
    input  port_data_t debug_bus,
    input  port_data_t vram_din,
    input  logic       prog_lock,
    input  logic       prog_wr,
    input  port_id_t   prog_addr,
    input  port_data_t prog_data,
    input  sdram_req_t game_req,
    output sdram_rsp_t game_rsp,
    output sdram_req_t bank_req,
    input  sdram_rsp_t bank_rsp,
    output logic       led,
    output logic       locked,
    output port_data_t st_addr,
    output vram_wr_t   vram_wr,
    output port_data_t read_data,
    output logic       cpu_rst
);

    logic [5:0]  frame_cnt;
    time_t       uptime;
    logic        wd_bite;
    logic [31:0] key_bytes;
    logic [47:0] scratch;
    sdram_data_t sdram_word;
    logic        owner;
    logic        cheat_busy;

    // Processor side reset, also set by the watchdog
    always_ff @(posedge clk) begin
        cpu_rst <= prst | wd_bite;
    end

    cheat_timekeeper u_time (
        .clk, .prst, .lvbl, .timestamp, .bus,
        .frame_cnt, .uptime, .wd_bite
    );

    cheat_lock u_lock (
        .clk, .prst, .bus,
        .prog_lock, .prog_wr, .prog_addr, .prog_data,
        .key_bytes, .locked
    );

    cheat_sdram_arbiter u_arb (
        .clk, .prst, .bus, .locked, .scratch,
        .game_req, .game_rsp, .bank_req, .bank_rsp,
        .sdram_word, .owner, .cheat_busy
    );

    cheat_port_bus u_ports (
        .clk, .prst(cpu_rst), .bus,
        .flags, .status, .joy1, .joy2, .st_dout, .debug_bus, .vram_din,
        .frame_cnt, .uptime, .timestamp, .key_bytes, .locked,
        .sdram_word, .owner, .cheat_busy, .lvbl,
        .scratch, .st_addr, .led, .vram_wr, .read_data
    );

endmodule

// ==== verification/tb_clock_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset
// 20 ns clock, reset held for
// the first three cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_clock_gen (
    output logic clk,
    output logic prst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        prst = 1'b1;
        repeat (3) @(posedge clk);
        #2 prst = 1'b0;    // Released just after the third edge
    end

endmodule

// ==== verification/tb_cheat_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cheat engine testbench
// Plays the processor, the game and
// the SDRAM bank from a stimulus table
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_cheat_top import cheat_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_GAME, OP_FRAMES} op_t;
    typedef struct {
        op_t        op;
        port_id_t   port;    // Kick flag for frame pulses
        port_data_t data;    // Frame count for frame pulses
        port_data_t exp;
    } entry_t;

    localparam int BANK_LAT = 3;
    localparam int WAIT_MAX = 60;

    logic       clk, prst, lvbl, prog_lock, prog_wr, led, locked, cpu_rst;
    time_t      timestamp, flags, status;
    port_bus_t  bus;
    port_data_t joy1, joy2, st_dout, debug_bus, vram_din, prog_data, st_addr, read_data;
    port_id_t   prog_addr;
    sdram_req_t game_req, bank_req;
    sdram_rsp_t game_rsp, bank_rsp;
    vram_wr_t   vram_wr;

    entry_t      table_q[$];
    port_data_t  sc[6];          // Shadow of the scratch ports
    sdram_addr_t bank_addr;
    int          bank_cnt;
    int          rst_seen;

    tb_clock_gen u_clk (.clk, .prst);

    cheat_top i_dut (.*);

    function automatic sdram_data_t bank_word(input sdram_addr_t a);
        return a[15:0] ^ 16'hc35a;
    endfunction

    // Bank model sampling the request 1 ns after the edge
    always @(posedge clk) begin
        #1;
        if (bank_cnt != 0) begin
            bank_cnt = bank_cnt + 1;
        end else if (bank_req.rd || bank_req.wr) begin
            bank_cnt  = 1;
            bank_addr = bank_req.addr;
        end
        bank_rsp.ack  = bank_cnt == BANK_LAT;
        bank_rsp.dst  = bank_cnt == BANK_LAT + 1;
        bank_rsp.data = bank_rsp.dst ? bank_word(bank_addr) : '0;
        bank_rsp.rdy  = bank_cnt == BANK_LAT + 2;
        if (bank_rsp.rdy) begin
            bank_cnt = 0;
        end
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Testbench failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_port_data(input port_data_t got, input port_data_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: %s is %02h, expected %02h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_sdram_req(input sdram_req_t got, input sdram_req_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input bit got, input bit exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: %s is %0b, expected %0b",
                                $time, what, got, exp));
        end
    endtask

    // Inputs change 2 ns after each rising edge
    task automatic step();
        @(posedge clk);
        #2;
        if (cpu_rst) rst_seen++;
    endtask

    function automatic bit event_seen(input int which);
        case (which)
            0:       return bank_req.rd;
            1:       return bank_rsp.rdy;
            2:       return game_rsp.ack;
            3:       return game_rsp.rdy;
            4:       return rst_seen != 0;
            default: return !prst && !cpu_rst;
        endcase
    endfunction

    task automatic wait_until(input int which, input string what);
        int n;
        n = 0;
        while (!event_seen(which) && n < WAIT_MAX) begin
            step();
            n++;
        end
        if (!event_seen(which)) begin
            abort_run($sformatf("Timed out at %0t ns waiting for %s", $time, what));
        end
    endtask

    task automatic write_port(input port_id_t port, input port_data_t data);
        bus              = '0;
        bus.port_id      = port;
        bus.out_port     = data;
        bus.write_strobe = 1'b1;
        step();
        bus = '0;
    endtask

    task automatic read_port(input port_id_t port, output port_data_t data);
        bus             = '0;
        bus.port_id     = port;
        bus.read_strobe = 1'b1;
        step();
        bus  = '0;
        data = read_data;    // One cycle after the strobe
    endtask

    // Address from ports 0..2, data 3..4, mask 5
    function automatic sdram_req_t expected_req();
        sdram_req_t r;
        r.addr  = {sc[2][5:0], sc[1], sc[0]};
        r.rd    = 1'b1;
        r.wr    = 1'b0;
        r.din   = {sc[4], sc[3]};
        r.din_m = sc[5][1:0];
        return r;
    endfunction

    task automatic cheat_transfer(input bit served);
        if (!served) begin
            repeat (4) begin
                check_flag(bank_req.rd | bank_req.wr, 1'b0, "bank request while locked");
                step();
            end
        end else begin
            wait_until(0, "cheat read on the bank");
            check_sdram_req(bank_req, expected_req(), "cheat bank request");
            wait_until(1, "bank rdy of the cheat read");
            step();
        end
    endtask

    task automatic check_vram_pulse(input port_data_t data);
        int pulses;
        pulses = 0;
        check_port_data(vram_wr.data, {1'b1, data[6:0]}, "vram data");
        repeat (4) begin
            if (vram_wr.we) pulses++;
            step();
        end
        check_flag(pulses == 1, 1'b1, "single vram we pulse");
    endtask

    // Game read raised while a cheat read is already pending
    task automatic game_and_cheat();
        sdram_req_t g;
        g                = '0;
        g.addr           = sdram_addr_t'($urandom);
        g.rd             = 1'b1;
        bus              = '0;
        bus.port_id      = PORT_CTRL;
        bus.write_strobe = 1'b1;
        step();
        bus      = '0;
        game_req = g;
        step();
        check_sdram_req(bank_req, g, "bank request with game first");
        wait_until(2, "game ack");
        game_req = '0;
        wait_until(3, "game rdy");
        cheat_transfer(1'b1);
    endtask

    task automatic frame_pulses(input int count, input bit kick);
        repeat (count) begin
            lvbl = 1'b1;
            step();
            lvbl = 1'b0;
            step();
            if (kick) write_port(8'h40, 8'h00);
        end
    endtask

    task automatic add_entry(input op_t op, input port_id_t port, input port_data_t data,
                             input port_data_t exp);
        entry_t e;
        e = '{op, port, data, exp};
        table_q.push_back(e);
    endtask

    task automatic build_table();
        port_data_t  s[6];
        sdram_data_t word;
        time_t       up;
        for (int i = 0; i < 6; i++) begin
            s[i] = port_data_t'($urandom);
            add_entry(OP_WR, port_id_t'(i), s[i], 8'h00);
        end
        for (int i = 0; i < 6; i++) add_entry(OP_RD, port_id_t'(i), 8'h00, s[i]);
        add_entry(OP_WR, PORT_LED, 8'h01, 8'h00);
        add_entry(OP_WR, PORT_ST_ADDR, 8'h5c, 8'h00);
        for (int i = 0; i < 4; i++) begin
            add_entry(OP_RD, PORT_FLAGS + port_id_t'(i), 8'h00, flags[8*i +: 8]);
            add_entry(OP_RD, PORT_STATUS + port_id_t'(i), 8'h00, status[8*i +: 8]);
            add_entry(OP_RD, 8'h24 + port_id_t'(i), 8'h00, BUILD_TIME[8*i +: 8]);
        end
        add_entry(OP_RD, PORT_JOY1, 8'h00, joy1);
        add_entry(OP_RD, PORT_JOY2, 8'h00, joy2);
        add_entry(OP_WR, PORT_VRAM_BASE + 8'd2, 8'h3b, 8'h00);
        add_entry(OP_RD, 8'h09, 8'h00, 8'h00);    // Unmapped
        add_entry(OP_RD, 8'h60, 8'h00, 8'h00);
        // Locked engine refuses the transfer
        add_entry(OP_WR, PORT_CTRL, 8'h00, 8'h00);
        add_entry(OP_RD, PORT_CTRL, 8'h00, 8'h01);
        for (int i = 0; i < 4; i++) begin
            add_entry(OP_WR, PORT_KEY + port_id_t'(i), UNLOCK_KEY[8*i +: 8], 8'h00);
        end
        for (int i = 0; i < 4; i++) begin
            add_entry(OP_RD, PORT_KEY + port_id_t'(i), 8'h00, UNLOCK_KEY[8*i +: 8]);
        end
        add_entry(OP_RD, PORT_CTRL, 8'h00, 8'h00);
        add_entry(OP_WR, PORT_CTRL, 8'h00, 8'h01);
        word = bank_word({s[2][5:0], s[1], s[0]});
        add_entry(OP_RD, PORT_SDRAM_LSB, 8'h00, word[7:0]);
        add_entry(OP_RD, PORT_SDRAM_MSB, 8'h00, word[15:8]);
        add_entry(OP_RD, PORT_CTRL, 8'h00, 8'h00);    // Owner and busy released
        s[0] = port_data_t'($urandom);
        add_entry(OP_WR, 8'h00, s[0], 8'h00);
        add_entry(OP_GAME, 8'h00, 8'h00, 8'h00);
        word = bank_word({s[2][5:0], s[1], s[0]});
        add_entry(OP_RD, PORT_SDRAM_LSB, 8'h00, word[7:0]);
        add_entry(OP_RD, PORT_SDRAM_MSB, 8'h00, word[15:8]);
        // One second of frames, then the watchdog
        add_entry(OP_FRAMES, 8'h01, 8'(FRAMES_PER_SEC), 8'h00);
        up = timestamp + 32'd1;
        for (int i = 0; i < 4; i++) begin
            add_entry(OP_RD, 8'h28 + port_id_t'(i), 8'h00, up[8*i +: 8]);
        end
        add_entry(OP_RD, 8'h2c, 8'h00, 8'h00);
        add_entry(OP_FRAMES, 8'h00, 8'(WATCHDOG_FRAMES), 8'h01);
        add_entry(OP_FRAMES, 8'h01, 8'd20, 8'h00);
    endtask

    task automatic apply_entry(input entry_t e);
        port_data_t d;
        case (e.op)
            OP_WR: begin
                write_port(e.port, e.data);
                if (e.port <= PORT_SCRATCH_LAST) sc[e.port[2:0]] = e.data;
                if (e.port == PORT_LED) check_flag(led, e.data[0], "led");
                if (e.port == PORT_ST_ADDR) check_port_data(st_addr, e.data, "st_addr");
                if (e.port == PORT_VRAM_BASE + 8'd2) check_vram_pulse(e.data);
                if (e.port[7]) cheat_transfer(e.exp[0]);
            end
            OP_RD: begin
                read_port(e.port, d);
                check_port_data(d, e.exp, $sformatf("port %02h", e.port));
                if (e.port == PORT_CTRL) check_flag(locked, e.exp[0], "locked");
            end
            OP_GAME: game_and_cheat();
            default: begin
                rst_seen = 0;
                frame_pulses(e.data, e.port[0]);
                if (e.exp[0]) begin
                    wait_until(4, "watchdog cpu_rst");
                end else begin
                    repeat (4) step();
                end
                check_flag(rst_seen != 0, e.exp[0], "cpu_rst from watchdog");
            end
        endcase
    endtask

    initial begin
        void'($urandom(32'h8015a3b4));
        lvbl      = 1'b0;
        timestamp = $urandom;
        flags     = $urandom;
        status    = $urandom;
        joy1      = port_data_t'($urandom);
        joy2      = port_data_t'($urandom);
        st_dout   = 8'h00;
        debug_bus = 8'h00;
        vram_din  = 8'h00;
        bus       = '0;
        prog_lock = 1'b0;
        prog_wr   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        game_req  = '0;
        bank_rsp  = '0;
        bank_cnt  = 0;
        rst_seen  = 0;
        wait_until(5, "reset release");
        build_table();
        foreach (table_q[i]) apply_entry(table_q[i]);
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== sources.f ====
hdl/cheat_pkg.sv
hdl/cheat_timekeeper.sv
hdl/cheat_lock.sv
hdl/cheat_sdram_arbiter.sv
hdl/cheat_port_bus.sv
hdl/cheat_top.sv
verification/tb_clock_gen.sv
verification/tb_cheat_top.sv

// ==== Bender.yml ====
package:
  name: cheat_engine

sources:
  - files:
      - hdl/cheat_pkg.sv
      - hdl/cheat_timekeeper.sv
      - hdl/cheat_lock.sv
      - hdl/cheat_sdram_arbiter.sv
      - hdl/cheat_port_bus.sv
      - hdl/cheat_top.sv
  - target: simulation
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_cheat_top.sv
